// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_mips_cpu
RTL_TOP    ?= mips_cpu
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////
    typedef logic [31:0] word_t;      // data, address or instruction
    typedef logic [4:0]  reg_addr_t;  // register file index
    typedef logic [5:0]  opcode_t;    // op field

    // opcodes of the kept subset
    localparam opcode_t OP_RTYPE = 6'b000_000;
    localparam opcode_t OP_J     = 6'b000_010;
    localparam opcode_t OP_BEQ   = 6'b000_100;
    localparam opcode_t OP_BNE   = 6'b000_101;
    localparam opcode_t OP_ADDIU = 6'b001_001;
    localparam opcode_t OP_LW    = 6'b100_011;
    localparam opcode_t OP_SW    = 6'b101_011;

    // funct codes inside the r-type group
    localparam logic [5:0] FUNCT_ADDU = 6'b100_001;
    localparam logic [5:0] FUNCT_OR   = 6'b100_101;
    localparam logic [5:0] FUNCT_SLT  = 6'b101_010;

    // instruction register view
    typedef struct packed {
        opcode_t   op;
        reg_addr_t rs;
        reg_addr_t rt;
        logic [15:0] imm16;  // [15:11] rd, [5:0] funct
    } instr_t;

    ////////////////////////////////////////
    // control encodings
    ////////////////////////////////////////
    typedef enum logic [1:0] {alu_add, alu_sub, alu_or, alu_slt} alu_op_e;

    typedef enum logic {src_a_pc, src_a_reg} src_a_e;

    typedef enum logic [1:0] {
        src_b_reg, src_b_four, src_b_imm, src_b_imm_shift
    } src_b_e;

    typedef enum logic [1:0] {pc_src_alu, pc_src_alu_out, pc_src_jump} pc_src_e;

    // one cycle of datapath control, 15 bits
    typedef struct packed {
        logic    pc_write;      // unconditional pc load
        logic    pc_write_beq;  // load on zero
        logic    pc_write_bne;  // load on not zero
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    mem_to_reg;    // write back mdr instead of alu_out
        logic    reg_dst_rd;    // rd instead of rt
        pc_src_e pc_src;
        alu_op_e alu_op;
        src_a_e  src_a;
        src_b_e  src_b;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== exec_unit.sv ====
`default_nettype none

module exec_unit import cpu_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire ctrl_t  ctrl,
    input  wire instr_t ir,
    input  wire word_t  pc,
    input  wire word_t  rdata1,  // rs read
    input  wire word_t  rdata2,  // rt read
    output word_t       alu_result,
    output word_t       alu_out,
    output logic        zero,
    output word_t       b_reg
);

    word_t a_reg;
    word_t imm_ext;    // sign-extended imm16
    word_t imm_shift;  // branch offset in bytes
    word_t alu_a;
    word_t alu_b;

    ////////////////////////////////////////
    // operand latches
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            a_reg <= '0;
            b_reg <= '0;
        end
        else
        begin
            a_reg <= rdata1;  // reloaded every cycle
            b_reg <= rdata2;  // also the store data
        end
    end

    ////////////////////////////////////////
    // operand select
    ////////////////////////////////////////
    assign imm_ext   = {{16{ir.imm16[15]}}, ir.imm16};
    assign imm_shift = {imm_ext[29:0], 2'b00};

    assign alu_a = (ctrl.src_a == src_a_reg) ? a_reg : pc;

    always_comb
    begin
        case (ctrl.src_b)
            src_b_reg:       alu_b = b_reg;
            src_b_four:      alu_b = 32'd4;  // pc increment
            src_b_imm:       alu_b = imm_ext;
            src_b_imm_shift: alu_b = imm_shift;
            default:         alu_b = b_reg;
        endcase
    end

    ////////////////////////////////////////
    // alu
    ////////////////////////////////////////
    always_comb
    begin
        case (ctrl.alu_op)
            alu_add: alu_result = alu_a + alu_b;
            alu_sub: alu_result = alu_a - alu_b;  // beq/bne compare
            alu_or:  alu_result = alu_a | alu_b;
            alu_slt: alu_result = ($signed(alu_a) < $signed(alu_b)) ? 32'd1 : 32'd0;
            default: alu_result = alu_a + alu_b;
        endcase
    end

    assign zero = (alu_result == '0);

    // result held one cycle for address, branch target, write back
    always_ff @(posedge clk)
    begin
        if (rst)
            alu_out <= '0;
        else
            alu_out <= alu_result;
    end

endmodule

`default_nettype wire

// ==== instr_decode.sv ====
`default_nettype none

module instr_decode import cpu_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire word_t instruction,  // from instruction port
    output instr_t     ir,
    output ctrl_t      ctrl
);

    typedef enum logic [3:0] {
        fetch, decode,
        mem_addr, load_read, load_wb, store,
        r_exec, r_wb, imm_exec, imm_wb,
        beq_cmp, bne_cmp, jump
    } state_e;

    state_e  state;
    state_e  next_state;
    logic    ir_write;
    alu_op_e r_alu_op;  // r-type op from funct

    ////////////////////////////////////////
    // instruction register
    ////////////////////////////////////////
    assign ir_write = (state == fetch);

    always_ff @(posedge clk)
    begin
        if (rst)
            ir <= '0;
        else if (ir_write)
            ir <= instruction;  // captured at end of fetch
    end

    ////////////////////////////////////////
    // state machine
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
            state <= fetch;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = fetch;  // most states end the instruction
        case (state)
            fetch:    next_state = decode;
            decode:
            begin
                case (ir.op)
                    OP_LW, OP_SW: next_state = mem_addr;
                    OP_RTYPE:     next_state = r_exec;
                    OP_ADDIU:     next_state = imm_exec;
                    OP_BEQ:       next_state = beq_cmp;
                    OP_BNE:       next_state = bne_cmp;
                    OP_J:         next_state = jump;
                    default:      next_state = fetch;  // unsupported, skip
                endcase
            end
            mem_addr: next_state = (ir.op == OP_LW) ? load_read : store;
            load_read: next_state = load_wb;
            r_exec:   next_state = r_wb;
            imm_exec: next_state = imm_wb;
            default:  next_state = fetch;
        endcase
    end

    // funct decode, unknown codes fall back to addu
    always_comb
    begin
        case (ir.imm16[5:0])
            FUNCT_ADDU: r_alu_op = alu_add;
            FUNCT_OR:   r_alu_op = alu_or;
            FUNCT_SLT:  r_alu_op = alu_slt;
            default:    r_alu_op = alu_add;
        endcase
    end

    ////////////////////////////////////////
    // control per state
    ////////////////////////////////////////
    always_comb
    begin
        ctrl = '0;  // everything idle, alu_add, pc/reg sources
        case (state)
            fetch:
            begin
                ctrl.pc_write = 1'b1;        // pc <= pc + 4
                ctrl.src_b    = src_b_four;
            end
            decode:    ctrl.src_b = src_b_imm_shift;  // branch target into alu_out
            mem_addr:
            begin
                ctrl.src_a = src_a_reg;
                ctrl.src_b = src_b_imm;
            end
            load_read: ctrl.mem_read = 1'b1;
            load_wb:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            store:     ctrl.mem_write = 1'b1;
            r_exec:
            begin
                ctrl.src_a  = src_a_reg;
                ctrl.alu_op = r_alu_op;
            end
            r_wb:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst_rd = 1'b1;
            end
            imm_exec:
            begin
                ctrl.src_a = src_a_reg;
                ctrl.src_b = src_b_imm;
            end
            imm_wb:    ctrl.reg_write = 1'b1;  // rt <= alu_out
            beq_cmp, bne_cmp:
            begin
                ctrl.src_a        = src_a_reg;
                ctrl.alu_op       = alu_sub;  // zero means equal
                ctrl.pc_src       = pc_src_alu_out;
                ctrl.pc_write_beq = (state == beq_cmp);
                ctrl.pc_write_bne = (state == bne_cmp);
            end
            jump:
            begin
                ctrl.pc_write = 1'b1;
                ctrl.pc_src   = pc_src_jump;
            end
            default: ;
        endcase
    end

    // a load and a store never share a cycle
    assert property (@(posedge clk) disable iff (rst) !(ctrl.mem_read && ctrl.mem_write));

    assert property (@(posedge clk) disable iff (rst)
        state inside {fetch, decode, mem_addr, load_read, load_wb, store,
                      r_exec, r_wb, imm_exec, imm_wb, beq_cmp, bne_cmp, jump});

endmodule

`default_nettype wire

// ==== list.f ====
cpu_pkg.sv
instr_decode.sv
exec_unit.sv
reg_file.sv
writeback_pc.sv
mips_cpu.sv
tb_mips_cpu.sv

// ==== mips_cpu.sv ====
`default_nettype none

module mips_cpu import cpu_pkg::*;
#(
    parameter word_t reset_pc = '0
)
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire word_t instruction,  // instruction port, same cycle
    input  wire word_t read_data,    // data port, same cycle
    output word_t      pc,
    output word_t      address,
    output word_t      write_data,
    output logic       mem_read,
    output logic       mem_write
);

    instr_t    ir;
    ctrl_t     ctrl;
    word_t     rdata1;
    word_t     rdata2;
    word_t     alu_result;
    word_t     alu_out;
    logic      zero;
    word_t     b_reg;
    reg_addr_t wb_addr;
    word_t     wb_data;

    ////////////////////////////////////////
    // units
    ////////////////////////////////////////
    instr_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .ir          (ir),
        .ctrl        (ctrl)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (ir.rs),
        .raddr2 (ir.rt),
        .we     (ctrl.reg_write),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    exec_unit u_exec (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .ir         (ir),
        .pc         (pc),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .alu_result (alu_result),
        .alu_out    (alu_out),
        .zero       (zero),
        .b_reg      (b_reg)
    );

    writeback_pc #(
        .reset_pc (reset_pc)
    ) u_wb (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .ir         (ir),
        .read_data  (read_data),
        .alu_result (alu_result),
        .alu_out    (alu_out),
        .zero       (zero),
        .pc         (pc),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    // data port
    assign address    = alu_out;  // computed in mem_addr
    assign write_data = b_reg;    // rt latch
    assign mem_read   = ctrl.mem_read;
    assign mem_write  = ctrl.mem_write;

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`default_nettype none

module reg_file import cpu_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire reg_addr_t raddr1,
    input  wire reg_addr_t raddr2,
    input  wire logic      we,
    input  wire reg_addr_t waddr,
    input  wire word_t     wdata,
    output word_t          rdata1,
    output word_t          rdata2
);

    word_t regs [32];

    // write at the edge, all cleared on reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (we && (waddr != '0))  // r0 not writable
        begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, r0 stays zero through reset and the write guard
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // r0 reads zero on either port
    assert property (@(posedge clk) disable iff (rst) (raddr1 == '0) |-> (rdata1 == '0));
    assert property (@(posedge clk) disable iff (rst) (raddr2 == '0) |-> (rdata2 == '0));

endmodule

`default_nettype wire

// ==== tb_mips_cpu.sv ====
`default_nettype none

module tb_mips_cpu
    import cpu_pkg::*;
();

    localparam int    clk_period     = 8;
    localparam int    timeout_cycles = 5 * 256 + 64;  // worst case cpi times program, plus slack
    localparam word_t final_pc       = 32'h0000_03fc;  // word 255, jump to itself

    logic  clk;
    logic  rst;
    word_t instruction;
    word_t read_data;
    word_t pc;
    word_t address;
    word_t write_data;
    logic  mem_read;
    logic  mem_write;

    word_t imem [256];   // program
    word_t dmem [64];    // data memory seen by the dut
    word_t m_regs [32];  // isa model state
    word_t m_mem [64];
    word_t m_pc;
    word_t rng_state;

    mips_cpu #(
        .reset_pc (32'h0)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .read_data   (read_data),
        .pc          (pc),
        .address     (address),
        .write_data  (write_data),
        .mem_read    (mem_read),
        .mem_write   (mem_write)
    );

    ////////////////////////////////////////
    // clock and memories
    ////////////////////////////////////////
    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    assign instruction = imem[pc[9:2]];        // same-cycle fetch
    assign read_data   = dmem[address[7:2]];   // same-cycle read

    always @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 64; i++)
                dmem[i] <= fill_word(i);  // pattern refilled during reset
        end
        else if (mem_write)
            dmem[address[7:2]] <= write_data;
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    function automatic logic [15:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];  // high half, better spread
    endfunction

    function automatic int pick(int n);
        logic [31:0] v;
        v = {16'h0000, lcg_next()};
        return int'(v % n);
    endfunction

    // initial data word, scrambled by index
    function automatic word_t fill_word(int idx);
        return 32'h5a5a_0000 ^ (32'(idx) * 32'h9e37_79b1);
    endfunction

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_pc(word_t exp);
        if (pc !== exp)
        begin
            $display("error at %0t: pc expected %h, got %h", $time, exp, pc);
            stop_run();
        end
    endtask

    task automatic compare_store(word_t exp_addr, word_t exp_data);
        if (address !== exp_addr || write_data !== exp_data)
        begin
            $display("error at %0t: store expected [%h] = %h, got [%h] = %h",
                     $time, exp_addr, exp_data, address, write_data);
            stop_run();
        end
    endtask

    task automatic compare_strobe(string what, logic got, logic exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s expected %b, got %b", $time, what, exp, got);
            stop_run();
        end
    endtask

    ////////////////////////////////////////
    // random program, forward control flow only
    ////////////////////////////////////////
    task automatic gen_program();
        logic [15:0] r;
        logic [15:0] imm;
        logic [5:0]  funct;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        int          span;
        int          off;
        for (int i = 0; i < 255; i++)
        begin
            r    = lcg_next();
            imm  = lcg_next();
            rs   = r[4:0];
            rt   = r[9:5];
            rd   = r[14:10];
            span = (i > 247) ? 255 - i : 8;  // keep targets inside the program
            off  = pick(span);
            case (pick(14))
                0, 1:    imem[i] = {OP_LW, 5'd0, rt, 8'h00, imm[5:0], 2'b00};  // r0 base
                2, 3:    imem[i] = {OP_SW, 5'd0, rt, 8'h00, imm[5:0], 2'b00};
                4, 5, 6, 7:
                begin
                    case (r[15:14])
                        2'd0:    funct = FUNCT_ADDU;
                        2'd1:    funct = FUNCT_OR;
                        2'd2:    funct = FUNCT_SLT;
                        default: funct = 6'b100_000;  // unknown funct, acts as addu
                    endcase
                    imem[i] = {OP_RTYPE, rs, rt, rd, 5'd0, funct};
                end
                8, 9:    imem[i] = {OP_ADDIU, rs, rt, imm};
                10:      imem[i] = {OP_BEQ, rs, rt, off[15:0]};
                11:      imem[i] = {OP_BNE, rs, rt, off[15:0]};
                12:      imem[i] = {OP_J, 26'(i + 1 + off)};  // word index, upper bits zero
                default: imem[i] = {3'b111, r[2:0], rs, rt, imm};  // not in the subset
            endcase
        end
        imem[255] = {OP_J, 26'd255};  // park here
    endtask

    ////////////////////////////////////////
    // isa model, one instruction per call
    ////////////////////////////////////////
    task automatic set_reg(reg_addr_t dst, word_t val);
        if (dst != 5'd0)
            m_regs[dst] = val;
    endtask

    task automatic model_step(output int ncyc, output logic is_load, output logic is_store,
                              output word_t st_addr, output word_t st_data);
        word_t  raw;
        instr_t ins;
        word_t  pc4;
        word_t  a;
        word_t  b;
        word_t  imm_sx;
        word_t  ea;
        word_t  res;
        raw      = imem[m_pc[9:2]];
        ins      = raw;
        pc4      = m_pc + 32'd4;
        a        = m_regs[ins.rs];
        b        = m_regs[ins.rt];
        imm_sx   = {{16{ins.imm16[15]}}, ins.imm16};
        ea       = a + imm_sx;
        is_load  = 1'b0;
        is_store = 1'b0;
        st_addr  = '0;
        st_data  = '0;
        m_pc     = pc4;
        case (ins.op)
            OP_LW:
            begin
                ncyc    = 5;
                is_load = 1'b1;
                set_reg(ins.rt, m_mem[ea[7:2]]);
            end
            OP_SW:
            begin
                ncyc     = 4;
                is_store = 1'b1;
                st_addr  = ea;
                st_data  = b;
                m_mem[ea[7:2]] = b;
            end
            OP_RTYPE:
            begin
                ncyc = 4;
                case (ins.imm16[5:0])
                    FUNCT_OR:  res = a | b;
                    FUNCT_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:   res = a + b;
                endcase
                set_reg(ins.imm16[15:11], res);
            end
            OP_ADDIU:
            begin
                ncyc = 4;
                set_reg(ins.rt, ea);
            end
            OP_BEQ, OP_BNE:
            begin
                ncyc = 3;
                if ((a == b) == (ins.op == OP_BEQ))
                    m_pc = pc4 + (imm_sx << 2);  // taken, word offset
            end
            OP_J:
            begin
                ncyc = 3;
                m_pc = {pc4[31:28], raw[25:0], 2'b00};  // 26-bit instr_index
            end
            default: ncyc = 2;  // fetch, decode, nothing else
        endcase
    endtask

    // runs one instruction on both sides, called at a fetch cycle
    task automatic run_instruction();
        int    ncyc;
        logic  ld;
        logic  st;
        word_t sa;
        word_t sd;
        compare_pc(m_pc);
        model_step(ncyc, ld, st, sa, sd);
        for (int c = 0; c < ncyc; c++)
        begin
            compare_strobe("mem_read", mem_read, ld && (c == 3));  // load_read is cycle 3
            compare_strobe("mem_write", mem_write, st && (c == 3));
            if (st && (c == 3))
                compare_store(sa, sd);
            @(posedge clk);
            #1;
        end
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////
    initial
    begin
        rst       = 1'b1;
        rng_state = 32'hde39;
        m_pc      = 32'h0;
        for (int i = 0; i < 32; i++)
            m_regs[i] = '0;
        for (int i = 0; i < 64; i++)
            m_mem[i] = fill_word(i);  // same start as dmem
        gen_program();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_pc(32'h0);  // first fetch at address 0
        compare_strobe("mem_read", mem_read, 1'b0);
        compare_strobe("mem_write", mem_write, 1'b0);
        while (m_pc != final_pc)
            run_instruction();
        run_instruction();  // jump to itself once
        compare_pc(final_pc);
        $display("STATUS: PASS");
        $finish;
    end

    initial
    begin
        #(timeout_cycles * clk_period);
        $display("timeout, the processor never reached the final jump");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== writeback_pc.sv ====
`default_nettype none

module writeback_pc import cpu_pkg::*;
#(
    parameter word_t reset_pc = '0
)
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire ctrl_t  ctrl,
    input  wire instr_t ir,
    input  wire word_t  read_data,   // data port
    input  wire word_t  alu_result,  // this cycle
    input  wire word_t  alu_out,     // last cycle
    input  wire logic   zero,
    output word_t       pc,
    output reg_addr_t   wb_addr,
    output word_t       wb_data
);

    word_t mdr;
    word_t jump_target;
    word_t pc_next;
    logic  pc_en;

    ////////////////////////////////////////
    // write back
    ////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        mdr <= read_data;  // load data, one cycle late
    end

    assign wb_addr = ctrl.reg_dst_rd ? ir.imm16[15:11] : ir.rt;
    assign wb_data = ctrl.mem_to_reg ? mdr : alu_out;

    ////////////////////////////////////////
    // program counter
    ////////////////////////////////////////
    // pc already holds pc+4 here
    assign jump_target = {pc[31:28], ir.rs, ir.rt, ir.imm16, 2'b00};

    assign pc_en = ctrl.pc_write
                 | (ctrl.pc_write_beq &  zero)
                 | (ctrl.pc_write_bne & ~zero);

    always_comb
    begin
        case (ctrl.pc_src)
            pc_src_alu:     pc_next = alu_result;  // fetch increment
            pc_src_alu_out: pc_next = alu_out;     // branch target from decode
            pc_src_jump:    pc_next = jump_target;
            default:        pc_next = alu_result;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= reset_pc;
        else if (pc_en)
            pc <= pc_next;
    end

    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire
